// ==== logic/switchArb_macros.svh ====
`ifndef SWITCH_ARB_MACROS_SVH
`define SWITCH_ARB_MACROS_SVH

// Input ports of the slice: Local, North, East, West, South.
`define NUM_PORTS 5

// Flit field widths.
`define ID_W 3
`define LEN_W 12
`define DATA_W 32

// Flit identifier of a header flit, the one that carries the packet length.
`define FLIT_HEADER (`ID_W'(1))

`endif

// ==== logic/switchArbPkg.sv ====
`include "switchArb_macros.svh"

package switchArbPkg;

  // Rotation order of the arbiter follows the encoding order.
  typedef enum logic [2:0] {
    Local = 3'd0,
    North = 3'd1,
    East  = 3'd2,
    West  = 3'd3,
    South = 3'd4
  } portIdx_t;

  // Length is only meaningful in header flits.
  typedef struct packed {
    logic [`ID_W-1:0]   flitId;
    logic [`LEN_W-1:0]  length;
    logic [`DATA_W-1:0] data;
  } flit_t;

  typedef struct packed {
    logic  req;
    flit_t flit;
  } portIn_t;

  // One-hot arbiter state.
  // Bit 0 is idle, bit p+1 is port p (Local at bit 1 up to South at bit 5).
  typedef logic [`NUM_PORTS:0] grant_t;

  typedef struct packed {
    portIdx_t src;
    flit_t    flit;
  } outLink_t;

endpackage

// ==== logic/portCapture.sv ====
`include "switchArb_macros.svh"

module portCapture (
  input  logic                                   clk,
  input  logic                                   rst,
  input  switchArbPkg::portIn_t [`NUM_PORTS-1:0] ports,
  output switchArbPkg::portIn_t [`NUM_PORTS-1:0] capPorts,
  output logic [`NUM_PORTS-1:0]                  headerSeen
);

  // Stage one register. Only the request levels are cleared on reset.
  always_ff @(posedge clk)
  begin
    for (int p = 0; p < `NUM_PORTS; p++)
    begin
      capPorts[p].flit <= ports[p].flit;
      if (rst)
        capPorts[p].req <= 1'b0;
      else
        capPorts[p].req <= ports[p].req;
    end
  end

  // Header decode on the captured flit, independent of the request level.
  always_comb
  begin
    for (int p = 0; p < `NUM_PORTS; p++)
    begin
      headerSeen[p] = (capPorts[p].flit.flitId == `FLIT_HEADER);
    end
  end

endmodule

// ==== logic/portTimer.sv ====
`include "switchArb_macros.svh"

module portTimer (
  input  logic              clk,
  input  logic              rst,
  input  logic              loadLimit,
  input  logic [`LEN_W-1:0] length,
  input  logic              hold,
  output logic              expired
);

  logic [`LEN_W-1:0] limit;
  logic [`LEN_W-1:0] count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
      count <= '0;
    end
    else
    begin
      // Limit follows the most recent header offered on this port.
      if (loadLimit)
        limit <= length;
      if (hold)
        count <= count + 1'b1;
      else
        count <= '0;
    end
  end

  assign expired = (count == limit);

  // The arbiter must never hold a port whose count has reached its limit.
  assert property (@(posedge clk) disable iff (rst)
    hold |-> (count != limit))
    else $error("portTimer: port held at its length limit");

endmodule

// ==== logic/switchArbiter.sv ====
`include "switchArb_macros.svh"

module switchArbiter (
  input  logic                                   clk,
  input  logic                                   rst,
  input  switchArbPkg::portIn_t [`NUM_PORTS-1:0] capPorts,
  input  logic [`NUM_PORTS-1:0]                  headerSeen,
  output switchArbPkg::grant_t                   grant,
  output switchArbPkg::grant_t                   nextGrant
);

  import switchArbPkg::*;

  logic [`NUM_PORTS-1:0] reqVec;
  logic [`NUM_PORTS-1:0] keep;
  logic [`NUM_PORTS-1:0] expired;
  portIdx_t              holderIdx;
  logic                  holding;
  int                    startIdx;
  int                    scanIdx;
  logic                  found;

  // A port keeps the output while it requests and its timer runs.
  always_comb
  begin
    for (int p = 0; p < `NUM_PORTS; p++)
    begin
      reqVec[p] = capPorts[p].req;
      keep[p]   = grant[p + 1] & capPorts[p].req & ~expired[p];
    end
  end

  // Current owner of the output, if any.
  always_comb
  begin
    holderIdx = Local;
    holding   = 1'b0;
    for (int p = 0; p < `NUM_PORTS; p++)
    begin
      if (grant[p + 1])
      begin
        holderIdx = portIdx_t'(p);
        holding   = 1'b1;
      end
    end
  end

  // Next state. From idle the scan starts at Local, otherwise at the port
  // after the holder and wraps back to the holder itself.
  always_comb
  begin
    nextGrant = '0;
    found     = 1'b0;
    scanIdx   = 0;
    startIdx  = holding ? int'(holderIdx) + 1 : 0;
    if (|keep)
    begin
      nextGrant = grant;
    end
    else
    begin
      for (int off = 0; off < `NUM_PORTS; off++)
      begin
        scanIdx = (startIdx + off) % `NUM_PORTS;
        if (!found && reqVec[scanIdx])
        begin
          nextGrant[scanIdx + 1] = 1'b1;
          found                  = 1'b1;
        end
      end
      // Nobody requests.
      nextGrant[0] = ~found;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      grant <= grant_t'(1);
    else
      grant <= nextGrant;
  end

  for (genvar p = 0; p < `NUM_PORTS; p++)
  begin : genTimer
    portTimer timerInst (
      .clk       (clk),
      .rst       (rst),
      .loadLimit (headerSeen[p]),
      .length    (capPorts[p].flit.length),
      .hold      (keep[p]),
      .expired   (expired[p])
    );
  end

  assert property (@(posedge clk) disable iff (rst) $onehot(grant))
    else $error("switchArbiter: grant is not one-hot");

  // A newly granted port must have had a captured request when it was chosen.
  assert property (@(posedge clk) disable iff (rst)
    ($changed(grant) && !grant[0]) |-> |(grant[`NUM_PORTS:1] & $past(reqVec)))
    else $error("switchArbiter: grant moved to a port without a request");

endmodule

// ==== logic/switchTraversal.sv ====
`include "switchArb_macros.svh"

module switchTraversal (
  input  logic                                   clk,
  input  logic                                   rst,
  input  switchArbPkg::grant_t                   nextGrant,
  input  switchArbPkg::portIn_t [`NUM_PORTS-1:0] capPorts,
  output switchArbPkg::outLink_t                 outLink,
  output logic                                   outVld
);

  import switchArbPkg::*;

  portIdx_t srcIdx;
  flit_t    selFlit;

  // One-hot to index, and the crossbar mux for this output.
  always_comb
  begin
    srcIdx  = Local;
    selFlit = capPorts[0].flit;
    for (int p = 0; p < `NUM_PORTS; p++)
    begin
      if (nextGrant[p + 1])
      begin
        srcIdx  = portIdx_t'(p);
        selFlit = capPorts[p].flit;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      outVld <= 1'b0;
    else
      outVld <= ~nextGrant[0];
  end

  // Link register only loads on a real decision.
  always_ff @(posedge clk)
  begin
    if (!nextGrant[0])
    begin
      outLink.src  <= srcIdx;
      outLink.flit <= selFlit;
    end
  end

  assert property (@(posedge clk) disable iff (rst)
    !outVld |-> (outLink === $past(outLink)))
    else $error("switchTraversal: link changed without a valid decision");

endmodule

// ==== logic/switchArbTop.sv ====
`include "switchArb_macros.svh"

module switchArbTop (
  input  logic                                   clk,
  input  logic                                   rst,
  input  switchArbPkg::portIn_t [`NUM_PORTS-1:0] ports,
  output switchArbPkg::grant_t                   grant,
  output switchArbPkg::outLink_t                 outLink,
  output logic                                   outVld
);

  import switchArbPkg::*;

  portIn_t [`NUM_PORTS-1:0] capPorts;
  logic [`NUM_PORTS-1:0]    headerSeen;
  grant_t                   nextGrant;

  // Stage one.
  portCapture capture0 (
    .clk        (clk),
    .rst        (rst),
    .ports      (ports),
    .capPorts   (capPorts),
    .headerSeen (headerSeen)
  );

  // Stage two.
  switchArbiter arbiter0 (
    .clk        (clk),
    .rst        (rst),
    .capPorts   (capPorts),
    .headerSeen (headerSeen),
    .grant      (grant),
    .nextGrant  (nextGrant)
  );

  // Stage three, registered alongside grant.
  switchTraversal traversal0 (
    .clk       (clk),
    .rst       (rst),
    .nextGrant (nextGrant),
    .capPorts  (capPorts),
    .outLink   (outLink),
    .outVld    (outVld)
  );

endmodule

// ==== verification/switchArbTb.sv ====
`include "switchArb_macros.svh"

module switchArbTb;

  import switchArbPkg::*;

  localparam int NUM_TESTS = 6;
  // Reset, then the driven cycles of each test with its idle tail.
  localparam int TEST_CYCLES = 16 + 4 + 18 + 18 + 26 + 10 + 403;
  localparam int MAX_CYCLES = TEST_CYCLES + 40;

  typedef struct packed {
    int       due;
    int       testIdx;
    grant_t   grant;
    logic     vld;
    logic     linkKnown;
    outLink_t link;
  } prediction_t;

  logic                     clk;
  logic                     rst;
  portIn_t [`NUM_PORTS-1:0] portsIn;
  grant_t                   grant;
  outLink_t                 outLink;
  logic                     outVld;

  int          cycle;
  int          curTest;
  int          reportedTest;
  int          testChecks [NUM_TESTS];
  int          testErrors [NUM_TESTS];
  string       testNames [NUM_TESTS];
  prediction_t predQ [$];
  prediction_t checkEntry;
  logic [31:0] lfsr;

  // Reference model state.
  portIn_t [`NUM_PORTS-1:0] mCap;
  grant_t                   mGrant;
  logic [`LEN_W-1:0]        mLimit [`NUM_PORTS];
  logic [`LEN_W-1:0]        mCount [`NUM_PORTS];
  outLink_t                 mLink;
  logic                     mLinkKnown;

  switchArbTop dut0 (
    .clk     (clk),
    .rst     (rst),
    .ports   (portsIn),
    .grant   (grant),
    .outLink (outLink),
    .outVld  (outVld)
  );

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #50 clk = ~clk;
    end
  end

  always @(posedge clk)
  begin
    cycle <= cycle + 1;
  end

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken.
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic portIn_t makePort(input logic req, input logic [`ID_W-1:0] id,
                                       input logic [`LEN_W-1:0] len,
                                       input logic [`DATA_W-1:0] data);
    portIn_t pin;
    pin.req         = req;
    pin.flit.flitId = id;
    pin.flit.length = len;
    pin.flit.data   = data;
    return pin;
  endfunction

  function automatic portIn_t randomPort();
    portIn_t     pin;
    logic [31:0] bits;
    bits            = randBits(1);
    pin.req         = bits[0];
    bits            = randBits(`ID_W);
    pin.flit.flitId = bits[`ID_W-1:0];
    bits            = randBits(4);
    pin.flit.length = `LEN_W'(bits[3:0]);
    pin.flit.data   = randBits(`DATA_W);
    return pin;
  endfunction

  // One model step: capture the offered ports, decide, then update the timers.
  function automatic prediction_t refArbiter(input portIn_t [`NUM_PORTS-1:0] offered);
    prediction_t           e;
    logic [`NUM_PORTS-1:0] hold;
    grant_t                nxt;
    int                    holder;
    int                    winner;
    int                    cand;
    e      = '0;
    mCap   = offered;
    holder = -1;
    winner = -1;
    hold   = '0;
    nxt    = grant_t'(1);
    for (int p = 0; p < `NUM_PORTS; p++)
      if (mGrant[p + 1])
        holder = p;
    if (holder >= 0 && mCap[holder].req && mCount[holder] != mLimit[holder])
    begin
      hold[holder] = 1'b1;
      nxt          = mGrant;
      winner       = holder;
    end
    else
    begin
      // From idle Local comes first, otherwise the port after the holder.
      for (int off = 1; off <= `NUM_PORTS; off++)
      begin
        cand = (holder + off) % `NUM_PORTS;
        if (nxt[0] && mCap[cand].req)
        begin
          nxt    = grant_t'(1) << (cand + 1);
          winner = cand;
        end
      end
    end
    for (int p = 0; p < `NUM_PORTS; p++)
    begin
      if (mCap[p].flit.flitId == `FLIT_HEADER)
        mLimit[p] = mCap[p].flit.length;
      mCount[p] = hold[p] ? mCount[p] + 1'b1 : '0;
    end
    mGrant = nxt;
    if (winner >= 0)
    begin
      mLink.src  = portIdx_t'(winner[2:0]);
      mLink.flit = mCap[winner].flit;
      mLinkKnown = 1'b1;
    end
    e.grant     = nxt;
    e.vld       = (winner >= 0);
    e.linkKnown = mLinkKnown;
    e.link      = mLink;
    return e;
  endfunction

  task automatic drivePorts(input portIn_t [`NUM_PORTS-1:0] v);
    prediction_t e;
    @(posedge clk);
    portsIn <= v;
    e = refArbiter(v);
    // The counter still shows the previous edge; the result lands two edges on.
    e.due     = cycle + 3;
    e.testIdx = curTest;
    predQ.push_back(e);
  endtask

  task automatic checkGrant(input int idx, input grant_t expV, input grant_t actV);
    testChecks[idx]++;
    if (actV !== expV)
    begin
      testErrors[idx]++;
      $display("[ERROR] %s grant at cycle %0d: expected %b, actual %b",
               testNames[idx], cycle, expV, actV);
    end
  endtask

  task automatic checkLink(input int idx, input outLink_t expV, input outLink_t actV);
    testChecks[idx]++;
    if (actV !== expV)
    begin
      testErrors[idx]++;
      $display("[ERROR] %s outLink at cycle %0d: expected %h, actual %h",
               testNames[idx], cycle, expV, actV);
    end
  endtask

  task automatic checkVld(input int idx, input logic expV, input logic actV);
    testChecks[idx]++;
    if (actV !== expV)
    begin
      testErrors[idx]++;
      $display("[ERROR] %s outVld at cycle %0d: expected %b, actual %b",
               testNames[idx], cycle, expV, actV);
    end
  endtask

  task automatic reportTest(input int idx);
    $display("test %s: %0d checks, %0d errors", testNames[idx], testChecks[idx],
             testErrors[idx]);
  endtask

  // Outputs are sampled on the falling edge, away from the drive edge.
  always @(negedge clk)
  begin
    while (predQ.size() > 0 && predQ[0].due <= cycle)
    begin
      checkEntry = predQ.pop_front();
      if (checkEntry.testIdx != reportedTest)
      begin
        reportTest(reportedTest);
        reportedTest = checkEntry.testIdx;
      end
      checkGrant(checkEntry.testIdx, checkEntry.grant, grant);
      checkVld(checkEntry.testIdx, checkEntry.vld, outVld);
      if (checkEntry.linkKnown)
        checkLink(checkEntry.testIdx, checkEntry.link, outLink);
    end
  end

  task automatic runReset();
    curTest = 0;
    for (int i = 1; i <= 16; i++)
    begin
      @(posedge clk);
      if (i == 16)
        rst <= 1'b0;
      else
      begin
        @(negedge clk);
        checkGrant(0, grant_t'(1), grant);
        checkVld(0, 1'b0, outVld);
      end
    end
    repeat (4) drivePorts('0);
  endtask

  task automatic runHold();
    portIn_t [`NUM_PORTS-1:0] v;
    curTest = 1;
    v       = '0;
    v[0]    = makePort(1'b1, `FLIT_HEADER, 12'd4, 32'h1000_0000);
    drivePorts(v);
    for (int i = 1; i < 15; i++)
    begin
      v[0] = makePort(1'b1, 3'd2, 12'd0, 32'h1000_0000 + 32'(i));
      drivePorts(v);
    end
    repeat (3) drivePorts('0);
  endtask

  task automatic runRotation();
    portIn_t [`NUM_PORTS-1:0] v;
    curTest = 2;
    for (int i = 0; i < 16; i++)
    begin
      for (int p = 0; p < `NUM_PORTS; p++)
        v[p] = makePort(1'b1, `FLIT_HEADER, 12'd0, 32'h2000_0000 + 32'(p));
      drivePorts(v);
    end
    repeat (2) drivePorts('0);
  endtask

  task automatic runForwarding();
    portIn_t [`NUM_PORTS-1:0] v;
    curTest = 3;
    for (int i = 0; i < 24; i++)
    begin
      // Port number and cycle make every payload unique.
      for (int p = 0; p < `NUM_PORTS; p++)
        v[p] = makePort(1'b1, (i % 3 == 0) ? `FLIT_HEADER : 3'd2, 12'(p),
                        {8'(p), 8'ha5, 16'(i)});
      drivePorts(v);
    end
    repeat (2) drivePorts('0);
  endtask

  task automatic runRelease();
    portIn_t [`NUM_PORTS-1:0] v;
    curTest = 4;
    v       = '0;
    v[2]    = makePort(1'b1, `FLIT_HEADER, 12'd10, 32'h4200_0000);
    for (int i = 0; i < 3; i++)
    begin
      v[0] = makePort(1'b1, `FLIT_HEADER, 12'd10, 32'h4000_0000 + 32'(i));
      drivePorts(v);
    end
    // Local lets go early, East is next in line.
    v[0] = '0;
    repeat (4) drivePorts(v);
    // East lets go with nobody waiting.
    repeat (3) drivePorts('0);
  endtask

  task automatic runRandom();
    portIn_t [`NUM_PORTS-1:0] v;
    curTest = 5;
    for (int i = 0; i < 400; i++)
    begin
      for (int p = 0; p < `NUM_PORTS; p++)
        v[p] = randomPort();
      drivePorts(v);
    end
    repeat (3) drivePorts('0);
  endtask

  initial
  begin
    while (cycle < MAX_CYCLES)
      @(posedge clk);
    $display("Timeout: run did not end within %0d cycles", MAX_CYCLES);
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial
  begin
    int totalChecks;
    int totalErrors;
    rst          = 1'b1;
    portsIn      = '0;
    lfsr         = 32'h63e;
    reportedTest = 0;
    totalChecks  = 0;
    totalErrors  = 0;
    testNames[0] = "reset";
    testNames[1] = "hold";
    testNames[2] = "rotation";
    testNames[3] = "forwarding";
    testNames[4] = "release";
    testNames[5] = "random";
    mCap         = '0;
    mGrant       = grant_t'(1);
    mLink        = '0;
    mLinkKnown   = 1'b0;
    for (int p = 0; p < `NUM_PORTS; p++)
    begin
      mLimit[p] = '0;
      mCount[p] = '0;
    end

    runReset();
    runHold();
    runRotation();
    runForwarding();
    runRelease();
    runRandom();

    while (predQ.size() > 0)
      @(negedge clk);
    reportTest(reportedTest);
    for (int t = 0; t < NUM_TESTS; t++)
    begin
      totalChecks += testChecks[t];
      totalErrors += testErrors[t];
    end
    $display("Totals: %0d tests, %0d checks, %0d errors", NUM_TESTS, totalChecks,
             totalErrors);
    if (totalErrors == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// ==== switchArb.f ====
+incdir+logic
logic/switchArbPkg.sv
logic/portCapture.sv
logic/portTimer.sv
logic/switchArbiter.sv
logic/switchTraversal.sv
logic/switchArbTop.sv
verification/switchArbTb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = switchArbTb
FILELIST = switchArb.f
OBJ_DIR  = obj_dir
LOG      = sim.log

BIN  = $(OBJ_DIR)/V$(TOP)
SRCS = $(shell grep -v '^+' $(FILELIST))
HDRS = $(wildcard logic/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^Simulation finished: PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
